//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // bus widths
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = 4;
    // byte address, low two bits unused
    localparam int ADDR_BITS = 32;
    localparam int ID_BITS   = 4;
    // burst length minus one
    localparam int LEN_BITS  = 4;

    // ar and aw payload
    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]  len;
    } addr_req_t;

    // w payload
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [STRB_BITS-1:0] strb;
        logic                 last;
    } wdata_t;

    // r payload, response always okay
    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [DATA_BITS-1:0] data;
        logic                 last;
    } rdata_t;

    // b payload
    typedef struct packed {
        logic [ID_BITS-1:0] id;
    } bresp_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        RESP
    } slave_state_e;

    typedef enum logic [1:0] {
        FREE,
        READ_OWNED,
        WRITE_OWNED
    } arb_state_e;

endpackage

`default_nettype wire

//--- hdl/sram_array.sv
`default_nettype none

module sram_array #(
    parameter int  DEPTH     = 1024,
    localparam int WORD_BITS = $clog2(DEPTH)
) (
    input  wire                             ACLK,
    input  wire                             en,
    input  wire                             we,
    input  wire  [mem_pkg::STRB_BITS-1:0]   byte_we,
    input  wire  [WORD_BITS-1:0]            addr,
    input  wire  [mem_pkg::DATA_BITS-1:0]   wdata,
    output logic [mem_pkg::DATA_BITS-1:0]   rdata
);

    // behavioral stand-in for the macro
    logic [mem_pkg::DATA_BITS-1:0] mem [DEPTH];

    always_ff @(posedge ACLK) begin
        if (en) begin
            if (we) begin
                // only the enabled byte lanes change
                for (int i = 0; i < mem_pkg::STRB_BITS; i++) begin
                    if (byte_we[i]) begin
                        mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
            // read port, old word on a write cycle
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/sram_slave.sv
`default_nettype none

module sram_slave #(
    parameter int  DEPTH     = 1024,
    localparam int WORD_BITS = $clog2(DEPTH)
) (
    input  wire                             ACLK,
    input  wire                             ARESETn,
    // read address
    input  wire mem_pkg::addr_req_t         ar,
    input  wire                             ar_valid,
    output logic                            ar_ready,
    // write address
    input  wire mem_pkg::addr_req_t         aw,
    input  wire                             aw_valid,
    output logic                            aw_ready,
    // write data
    input  wire mem_pkg::wdata_t            w,
    input  wire                             w_valid,
    output logic                            w_ready,
    // read data
    output mem_pkg::rdata_t                 r,
    output logic                            r_valid,
    input  wire                             r_ready,
    // write response
    output mem_pkg::bresp_t                 b,
    output logic                            b_valid,
    input  wire                             b_ready,
    // array side
    output logic                            mem_en,
    output logic                            mem_we,
    output logic [mem_pkg::STRB_BITS-1:0]   mem_byte_we,
    output logic [WORD_BITS-1:0]            mem_addr,
    output logic [mem_pkg::DATA_BITS-1:0]   mem_wdata,
    input  wire  [mem_pkg::DATA_BITS-1:0]   mem_rdata
);

    mem_pkg::slave_state_e state;
    mem_pkg::slave_state_e state_nxt;

    // captured transaction fields
    logic [mem_pkg::ID_BITS-1:0]   id_q;
    logic [mem_pkg::LEN_BITS-1:0]  len_q;
    logic [mem_pkg::LEN_BITS-1:0]  cnt_q;
    // current and next word
    logic [WORD_BITS-1:0]          addr_q;
    logic [WORD_BITS-1:0]          nxt_q;

    // skid for stalled read beats
    logic                          hold_v;
    logic [mem_pkg::DATA_BITS-1:0] hold_q;

    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    logic r_fire;
    logic b_fire;

    // byte address to word index, wraps at DEPTH
    function automatic logic [WORD_BITS-1:0] word_of(input logic [mem_pkg::ADDR_BITS-1:0] a);
        return a[WORD_BITS+1:2];
    endfunction

    // write wins over read in idle
    assign aw_ready = (state == mem_pkg::IDLE);
    assign ar_ready = (state == mem_pkg::IDLE) && !aw_valid;
    assign w_ready  = (state == mem_pkg::WRITE);
    // word lands one cycle after each fetch, so valid for the whole burst
    assign r_valid  = (state == mem_pkg::READ);
    assign b_valid  = (state == mem_pkg::RESP);

    assign ar_fire = ar_valid && ar_ready;
    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign r_fire  = r_valid && r_ready;
    assign b_fire  = b_valid && b_ready;

    assign r = '{id: id_q, data: (hold_v ? hold_q : mem_rdata), last: (cnt_q == len_q)};
    assign b = '{id: id_q};

    // array control
    always_comb begin
        mem_en      = 1'b0;
        mem_we      = 1'b0;
        mem_addr    = addr_q;
        // strobes straight to byte enables
        mem_byte_we = w.strb;
        mem_wdata   = w.data;
        case (state)
            mem_pkg::IDLE: begin
                // first word fetched in the address cycle
                mem_en   = ar_fire;
                mem_addr = word_of(ar.addr);
            end
            mem_pkg::READ: begin
                // fetch next word as the current beat leaves
                mem_en   = r_fire && !r.last;
                mem_addr = nxt_q;
            end
            mem_pkg::WRITE: begin
                mem_en = w_fire;
                mem_we = w_fire;
            end
            default: begin
                mem_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mem_pkg::IDLE: begin
                if (aw_fire) begin
                    state_nxt = mem_pkg::WRITE;
                end else if (ar_fire) begin
                    state_nxt = mem_pkg::READ;
                end
            end
            mem_pkg::READ: begin
                if (r_fire && r.last) begin
                    state_nxt = mem_pkg::IDLE;
                end
            end
            mem_pkg::WRITE: begin
                // burst ends on w last, len not needed
                if (w_fire && w.last) begin
                    state_nxt = mem_pkg::RESP;
                end
            end
            default: begin
                if (b_fire) begin
                    state_nxt = mem_pkg::IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state  <= mem_pkg::IDLE;
            len_q  <= '0;
            cnt_q  <= '0;
            hold_v <= 1'b0;
        end else begin
            state <= state_nxt;
            if (ar_fire) begin
                len_q <= ar.len;
                cnt_q <= '0;
            end else if (r_fire) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // park r data while the master stalls
            if (r_fire) begin
                hold_v <= 1'b0;
            end else if (r_valid && !hold_v) begin
                hold_v <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            id_q   <= aw.id;
            addr_q <= word_of(aw.addr);
            nxt_q  <= word_of(aw.addr) + 1'b1;
        end else if (ar_fire) begin
            id_q   <= ar.id;
            addr_q <= word_of(ar.addr);
            nxt_q  <= word_of(ar.addr) + 1'b1;
        end else if (r_fire || w_fire) begin
            addr_q <= nxt_q;
            nxt_q  <= nxt_q + 1'b1;
        end
        if (r_valid && !r_ready && !hold_v) begin
            hold_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  wire                       ACLK,
    input  wire                       ARESETn,
    // master side, index 0 and 1
    input  wire mem_pkg::addr_req_t   m_ar [2],
    input  wire  [1:0]                m_ar_valid,
    output logic [1:0]                m_ar_ready,
    input  wire mem_pkg::addr_req_t   m_aw [2],
    input  wire  [1:0]                m_aw_valid,
    output logic [1:0]                m_aw_ready,
    input  wire mem_pkg::wdata_t      m_w [2],
    input  wire  [1:0]                m_w_valid,
    output logic [1:0]                m_w_ready,
    output mem_pkg::rdata_t           m_r [2],
    output logic [1:0]                m_r_valid,
    input  wire  [1:0]                m_r_ready,
    output mem_pkg::bresp_t           m_b [2],
    output logic [1:0]                m_b_valid,
    input  wire  [1:0]                m_b_ready,
    // slave side
    output mem_pkg::addr_req_t        s_ar,
    output logic                      s_ar_valid,
    input  wire                       s_ar_ready,
    output mem_pkg::addr_req_t        s_aw,
    output logic                      s_aw_valid,
    input  wire                       s_aw_ready,
    output mem_pkg::wdata_t           s_w,
    output logic                      s_w_valid,
    input  wire                       s_w_ready,
    input  wire mem_pkg::rdata_t      s_r,
    input  wire                       s_r_valid,
    output logic                      s_r_ready,
    input  wire mem_pkg::bresp_t      s_b,
    input  wire                       s_b_valid,
    output logic                      s_b_ready
);

    mem_pkg::arb_state_e state;
    // current owner, and last granted once free again
    logic       owner;
    logic [1:0] req;
    logic [1:0] grant;
    logic       pick;
    logic       rd_own;
    logic       wr_own;

    assign req = m_ar_valid | m_aw_valid;

    // alternate only on a tie
    assign pick = (req == 2'b11) ? ~owner : req[1];

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= mem_pkg::FREE;
            // so master 0 wins the first tie
            owner <= 1'b1;
        end else begin
            case (state)
                mem_pkg::FREE: begin
                    if (|req) begin
                        owner <= pick;
                        // write first if both channels are up
                        state <= m_aw_valid[pick] ? mem_pkg::WRITE_OWNED
                                                  : mem_pkg::READ_OWNED;
                    end
                end
                mem_pkg::READ_OWNED: begin
                    if (s_r_valid && s_r_ready && s_r.last) begin
                        state <= mem_pkg::FREE;
                    end
                end
                mem_pkg::WRITE_OWNED: begin
                    if (s_b_valid && s_b_ready) begin
                        state <= mem_pkg::FREE;
                    end
                end
                default: begin
                    state <= mem_pkg::FREE;
                end
            endcase
        end
    end

    assign rd_own = (state == mem_pkg::READ_OWNED);
    assign wr_own = (state == mem_pkg::WRITE_OWNED);
    assign grant  = (rd_own || wr_own) ? (owner ? 2'b10 : 2'b01) : 2'b00;

    // requests from the owner, gated by transaction kind
    assign s_ar       = m_ar[owner];
    assign s_ar_valid = rd_own && m_ar_valid[owner];
    assign s_aw       = m_aw[owner];
    assign s_aw_valid = wr_own && m_aw_valid[owner];
    assign s_w        = m_w[owner];
    assign s_w_valid  = wr_own && m_w_valid[owner];
    assign s_r_ready  = rd_own && m_r_ready[owner];
    assign s_b_ready  = wr_own && m_b_ready[owner];

    // handshakes back to the owner only
    assign m_ar_ready = grant & {2{rd_own && s_ar_ready}};
    assign m_r_valid  = grant & {2{rd_own && s_r_valid}};
    assign m_aw_ready = grant & {2{wr_own && s_aw_ready}};
    assign m_w_ready  = grant & {2{wr_own && s_w_ready}};
    assign m_b_valid  = grant & {2{wr_own && s_b_valid}};

    // payloads fan out, valids select the port
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            m_r[i] = s_r;
            m_b[i] = s_b;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_subsystem.sv
`default_nettype none

module mem_subsystem #(
    parameter int DEPTH = 1024
) (
    input  wire                       ACLK,
    input  wire                       ARESETn,
    // master ports 0 and 1
    input  wire mem_pkg::addr_req_t   ar [2],
    input  wire  [1:0]                ar_valid,
    output logic [1:0]                ar_ready,
    input  wire mem_pkg::addr_req_t   aw [2],
    input  wire  [1:0]                aw_valid,
    output logic [1:0]                aw_ready,
    input  wire mem_pkg::wdata_t      w [2],
    input  wire  [1:0]                w_valid,
    output logic [1:0]                w_ready,
    output mem_pkg::rdata_t           r [2],
    output logic [1:0]                r_valid,
    input  wire  [1:0]                r_ready,
    output mem_pkg::bresp_t           b [2],
    output logic [1:0]                b_valid,
    input  wire  [1:0]                b_ready
);

    localparam int WORD_BITS = $clog2(DEPTH);

    // arbiter to slave
    mem_pkg::addr_req_t s_ar;
    mem_pkg::addr_req_t s_aw;
    mem_pkg::wdata_t    s_w;
    mem_pkg::rdata_t    s_r;
    mem_pkg::bresp_t    s_b;
    logic s_ar_valid;
    logic s_ar_ready;
    logic s_aw_valid;
    logic s_aw_ready;
    logic s_w_valid;
    logic s_w_ready;
    logic s_r_valid;
    logic s_r_ready;
    logic s_b_valid;
    logic s_b_ready;

    // slave to array
    logic                          mem_en;
    logic                          mem_we;
    logic [mem_pkg::STRB_BITS-1:0] mem_byte_we;
    logic [WORD_BITS-1:0]          mem_addr;
    logic [mem_pkg::DATA_BITS-1:0] mem_wdata;
    logic [mem_pkg::DATA_BITS-1:0] mem_rdata;

    bus_arbiter u_arb (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .m_ar       (ar),
        .m_ar_valid (ar_valid),
        .m_ar_ready (ar_ready),
        .m_aw       (aw),
        .m_aw_valid (aw_valid),
        .m_aw_ready (aw_ready),
        .m_w        (w),
        .m_w_valid  (w_valid),
        .m_w_ready  (w_ready),
        .m_r        (r),
        .m_r_valid  (r_valid),
        .m_r_ready  (r_ready),
        .m_b        (b),
        .m_b_valid  (b_valid),
        .m_b_ready  (b_ready),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready),
        .s_b        (s_b),
        .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready)
    );

    sram_slave #(
        .DEPTH (DEPTH)
    ) u_slave (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .ar          (s_ar),
        .ar_valid    (s_ar_valid),
        .ar_ready    (s_ar_ready),
        .aw          (s_aw),
        .aw_valid    (s_aw_valid),
        .aw_ready    (s_aw_ready),
        .w           (s_w),
        .w_valid     (s_w_valid),
        .w_ready     (s_w_ready),
        .r           (s_r),
        .r_valid     (s_r_valid),
        .r_ready     (s_r_ready),
        .b           (s_b),
        .b_valid     (s_b_valid),
        .b_ready     (s_b_ready),
        .mem_en      (mem_en),
        .mem_we      (mem_we),
        .mem_byte_we (mem_byte_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

    sram_array #(
        .DEPTH (DEPTH)
    ) u_array (
        .ACLK    (ACLK),
        .en      (mem_en),
        .we      (mem_we),
        .byte_we (mem_byte_we),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

//--- bench/mem_checker.sv
`default_nettype none

module mem_checker #(
    parameter int DEPTH = 1024
) (
    input  wire                       ACLK,
    input  wire                       ARESETn,
    input  wire mem_pkg::addr_req_t   ar [2],
    input  wire  [1:0]                ar_valid,
    input  wire  [1:0]                ar_ready,
    input  wire mem_pkg::addr_req_t   aw [2],
    input  wire  [1:0]                aw_valid,
    input  wire  [1:0]                aw_ready,
    input  wire mem_pkg::wdata_t      w [2],
    input  wire  [1:0]                w_valid,
    input  wire  [1:0]                w_ready,
    input  wire mem_pkg::rdata_t      r [2],
    input  wire  [1:0]                r_valid,
    input  wire  [1:0]                r_ready,
    input  wire mem_pkg::bresp_t      b [2],
    input  wire  [1:0]                b_valid,
    input  wire  [1:0]                b_ready,
    output int                        errors,
    output int                        done_txns
);

    timeunit 1ns;
    timeprecision 1ps;

    // shadow of the array
    logic [31:0] shadow [DEPTH];

    int         err_cnt  = 0;
    int         done_cnt = 0;
    int         wr_word [2];
    int         rd_word [2];
    int         rd_beat [2];
    logic [3:0] wr_id   [2];
    logic [3:0] rd_id   [2];
    logic [3:0] rd_len  [2];
    logic       wr_open [2];
    logic       rd_open [2];

    assign errors    = err_cnt;
    assign done_txns = done_cnt;

    // byte address to word, modulo depth
    function automatic int word_index(input logic [31:0] a);
        return int'((a >> 2) % DEPTH);
    endfunction

    // old word with the strobed bytes replaced
    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                         input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = nw[8*i +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge ACLK) begin
        if (!ARESETn) begin
            for (int p = 0; p < 2; p++) begin
                wr_open[p] = 1'b0;
                rd_open[p] = 1'b0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                // responses only for an open transaction
                if (r_valid[p] && !rd_open[p]) begin
                    $display("r_valid on port %0d without an open read", p);
                    err_cnt++;
                end
                if (b_valid[p] && !wr_open[p]) begin
                    $display("b_valid on port %0d without an open write", p);
                    err_cnt++;
                end
                if (r_valid[p] && r_ready[p] && rd_open[p]) begin
                    if (r[p].data !== shadow[rd_word[p]]) begin
                        $display("Fail r[%0d].data: got %h, expected %h",
                                 p, r[p].data, shadow[rd_word[p]]);
                        err_cnt++;
                    end
                    if (r[p].id !== rd_id[p]) begin
                        $display("Fail r[%0d].id: got %h, expected %h", p, r[p].id, rd_id[p]);
                        err_cnt++;
                    end
                    if (r[p].last !== (rd_beat[p] == int'(rd_len[p]))) begin
                        $display("Fail r[%0d].last: got %h, expected %h at beat %h",
                                 p, r[p].last, (rd_beat[p] == int'(rd_len[p])), rd_beat[p]);
                        err_cnt++;
                    end
                    rd_word[p] = (rd_word[p] + 1) % DEPTH;
                    rd_beat[p]++;
                    if (r[p].last || rd_beat[p] > int'(rd_len[p])) begin
                        rd_open[p] = 1'b0;
                        done_cnt++;
                    end
                end
                if (w_valid[p] && w_ready[p]) begin
                    if (!wr_open[p]) begin
                        $display("w transfer on port %0d without a write address", p);
                        err_cnt++;
                    end
                    shadow[wr_word[p]] = merge(shadow[wr_word[p]], w[p].data, w[p].strb);
                    wr_word[p] = (wr_word[p] + 1) % DEPTH;
                end
                if (b_valid[p] && b_ready[p] && wr_open[p]) begin
                    if (b[p].id !== wr_id[p]) begin
                        $display("Fail b[%0d].id: got %h, expected %h", p, b[p].id, wr_id[p]);
                        err_cnt++;
                    end
                    wr_open[p] = 1'b0;
                    done_cnt++;
                end
                if (ar_valid[p] && ar_ready[p]) begin
                    rd_open[p] = 1'b1;
                    rd_word[p] = word_index(ar[p].addr);
                    rd_id[p]   = ar[p].id;
                    rd_len[p]  = ar[p].len;
                    rd_beat[p] = 0;
                end
                if (aw_valid[p] && aw_ready[p]) begin
                    wr_open[p] = 1'b1;
                    wr_word[p] = word_index(aw[p].addr);
                    wr_id[p]   = aw[p].id;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/mem_subsystem_asserts.sv
`default_nettype none

module mem_subsystem_asserts (
    input wire                       ACLK,
    input wire                       ARESETn,
    // per master, address taken and transaction closed
    input wire  [1:0]                addr_acc,
    input wire  [1:0]                txn_end,
    input wire mem_pkg::addr_req_t   ar,
    input wire                       ar_valid,
    input wire                       ar_ready,
    input wire mem_pkg::rdata_t      r,
    input wire                       r_valid,
    input wire                       r_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int         fail_cnt = 0;
    // own beat count per read burst
    int         beats;
    logic [3:0] len_cap;
    // transactions in flight, one bit per master
    logic [1:0] open_q;

    always @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            beats   <= 0;
            len_cap <= '0;
            open_q  <= '0;
        end else begin
            open_q <= (open_q | addr_acc) & ~txn_end;
            if (ar_valid && ar_ready) begin
                beats   <= 0;
                len_cap <= ar.len;
            end else if (r_valid && r_ready) begin
                beats <= beats + 1;
            end
        end
    end

    ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
        fail_cnt++;
        $error("ar dropped or changed before ready");
    end

    r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
        fail_cnt++;
        $error("r dropped or changed while stalled");
    end

    // a new address only once every earlier transaction has closed
    one_grant: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (|addr_acc) |-> $onehot0(addr_acc) && open_q == 2'b00)
    else begin
        fail_cnt++;
        $error("address taken while another transaction is still open");
    end

    last_len: assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_valid |-> (r.last == (beats == int'(len_cap))))
    else begin
        fail_cnt++;
        $error("r last does not match the burst length");
    end

endmodule

// slave serves one port, upper bit idle
bind sram_slave mem_subsystem_asserts u_slave_asserts (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .addr_acc ({1'b0, ar_fire || aw_fire}),
    .txn_end  ({1'b0, (r_fire && r.last) || b_fire}),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
);

bind bus_arbiter mem_subsystem_asserts u_arb_asserts (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .addr_acc ((m_ar_valid & m_ar_ready) | (m_aw_valid & m_aw_ready)),
    .txn_end  ((m_r_valid & m_r_ready & {m_r[1].last, m_r[0].last})
               | (m_b_valid & m_b_ready)),
    .ar       (s_ar),
    .ar_valid (s_ar_valid),
    .ar_ready (s_ar_ready),
    .r        (s_r),
    .r_valid  (s_r_valid),
    .r_ready  (s_r_ready)
);

`default_nettype wire

//--- bench/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 64;
    localparam int NUM   = 14;

    // one row of the stimulus table
    typedef struct packed {
        logic        master;
        logic        write;
        logic [3:0]  id;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [3:0]  strb;
        logic [31:0] seed;
        // start together with the next row
        logic        together;
        // random r_ready
        logic        rnd;
    } txn_t;

    logic ACLK;
    logic ARESETn;

    mem_pkg::addr_req_t ar [2];
    logic [1:0]         ar_valid;
    logic [1:0]         ar_ready;
    mem_pkg::addr_req_t aw [2];
    logic [1:0]         aw_valid;
    logic [1:0]         aw_ready;
    mem_pkg::wdata_t    w [2];
    logic [1:0]         w_valid;
    logic [1:0]         w_ready;
    mem_pkg::rdata_t    r [2];
    logic [1:0]         r_valid;
    logic [1:0]         r_ready;
    mem_pkg::bresp_t    b [2];
    logic [1:0]         b_valid;
    logic [1:0]         b_ready;

    int   chk_errors;
    int   done_txns;
    int   tb_errors;
    int   total;
    int   limit;
    txn_t tbl [NUM];

    mem_subsystem #(
        .DEPTH (DEPTH)
    ) DUT (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

    mem_checker #(
        .DEPTH (DEPTH)
    ) u_chk (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .errors    (chk_errors),
        .done_txns (done_txns)
    );

    initial begin
        ACLK = 1'b0;
        forever begin
            #2 ACLK = ~ACLK;
        end
    end

    // master driver, one port per call
    task automatic run_txn(input txn_t t);
        int p;
        bit done;
        p = int'(t.master);
        done = 1'b0;
        @(posedge ACLK);
        if (t.write) begin
            aw[p]       <= '{id: t.id, addr: t.addr, len: t.len};
            aw_valid[p] <= 1'b1;
            do @(posedge ACLK); while (!aw_ready[p]);
            aw_valid[p] <= 1'b0;
            for (int beat = 0; beat <= int'(t.len); beat++) begin
                // data word is seed plus beat index
                w[p]       <= '{data: t.seed + beat, strb: t.strb, last: (beat == int'(t.len))};
                w_valid[p] <= 1'b1;
                do @(posedge ACLK); while (!w_ready[p]);
            end
            w_valid[p] <= 1'b0;
            b_ready[p] <= 1'b1;
            do @(posedge ACLK); while (!b_valid[p]);
            b_ready[p] <= 1'b0;
        end else begin
            ar[p]       <= '{id: t.id, addr: t.addr, len: t.len};
            ar_valid[p] <= 1'b1;
            do @(posedge ACLK); while (!ar_ready[p]);
            ar_valid[p] <= 1'b0;
            while (!done) begin
                r_ready[p] <= t.rnd ? ($urandom() % 2 == 1) : 1'b1;
                @(posedge ACLK);
                if (r_valid[p] && r_ready[p] && r[p].last) begin
                    done = 1'b1;
                end
            end
            r_ready[p] <= 1'b0;
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge ACLK);
        $display("timeout: transactions did not finish within %0d cycles", cycles);
        $display("Finished with errors");
        $finish;
    endtask

    initial begin
        int i;
        void'($urandom(32'haf43_5bee));
        ARESETn = 1'b0;
        tb_errors = 0;
        for (int p = 0; p < 2; p++) begin
            ar[p] = '0;
            aw[p] = '0;
            w[p]  = '0;
        end
        ar_valid = '0;
        aw_valid = '0;
        w_valid  = '0;
        r_ready  = '0;
        b_ready  = '0;

        // master, write, id, addr, len, strb, seed, together, rnd
        tbl[0]  = '{1'b0, 1'b1, 4'h3, 32'h10,  4'd0,  4'hf, 32'h1122_3344, 1'b0, 1'b0};
        tbl[1]  = '{1'b0, 1'b0, 4'h5, 32'h10,  4'd0,  4'hf, 32'h0,         1'b0, 1'b0};
        // 16 beats from word 56, wraps past the top
        tbl[2]  = '{1'b1, 1'b1, 4'h7, 32'he0,  4'd15, 4'hf, 32'ha000_0000, 1'b0, 1'b0};
        tbl[3]  = '{1'b1, 1'b0, 4'h9, 32'he0,  4'd15, 4'hf, 32'h0,         1'b0, 1'b1};
        // high byte address aliases word 56
        tbl[4]  = '{1'b0, 1'b0, 4'h2, 32'h1e0, 4'd3,  4'hf, 32'h0,         1'b0, 1'b0};
        // partial strobes over known data
        tbl[5]  = '{1'b0, 1'b1, 4'h4, 32'h10,  4'd0,  4'h5, 32'hdead_beef, 1'b0, 1'b0};
        tbl[6]  = '{1'b1, 1'b0, 4'h6, 32'h10,  4'd0,  4'hf, 32'h0,         1'b0, 1'b0};
        // both masters in the same cycle
        tbl[7]  = '{1'b0, 1'b1, 4'h1, 32'h40,  4'd3,  4'hf, 32'h5555_0000, 1'b1, 1'b0};
        tbl[8]  = '{1'b1, 1'b0, 4'h8, 32'h00,  4'd3,  4'hf, 32'h0,         1'b0, 1'b0};
        tbl[9]  = '{1'b1, 1'b0, 4'ha, 32'h40,  4'd3,  4'hf, 32'h0,         1'b0, 1'b1};
        tbl[10] = '{1'b0, 1'b0, 4'hb, 32'h40,  4'd3,  4'hf, 32'h0,         1'b0, 1'b1};
        tbl[11] = '{1'b1, 1'b1, 4'hc, 32'h80,  4'd1,  4'hf, 32'h7777_0000, 1'b1, 1'b0};
        tbl[12] = '{1'b0, 1'b1, 4'hd, 32'h90,  4'd1,  4'h9, 32'h3333_0000, 1'b0, 1'b0};
        tbl[13] = '{1'b0, 1'b0, 4'he, 32'h80,  4'd1,  4'hf, 32'h0,         1'b0, 1'b1};

        total = 0;
        for (int k = 0; k < NUM; k++) begin
            total += int'(tbl[k].len) + 1;
        end
        limit = total * 40 + 1000;
        fork
            watchdog(limit);
        join_none

        repeat (16) @(posedge ACLK);
        ARESETn <= 1'b1;
        // idle stretch, no response may show up here
        repeat (5) @(posedge ACLK);

        i = 0;
        while (i < NUM) begin
            if (tbl[i].together && i + 1 < NUM) begin
                fork
                    run_txn(tbl[i]);
                    run_txn(tbl[i+1]);
                join
                i += 2;
            end else begin
                run_txn(tbl[i]);
                i += 1;
            end
        end
        repeat (5) @(posedge ACLK);

        if (done_txns != NUM) begin
            $display("only %0d of %0d transactions completed", done_txns, NUM);
            tb_errors++;
        end
        $display("errors: checker %0d, slave asserts %0d, arbiter asserts %0d, testbench %0d",
                 chk_errors, DUT.u_slave.u_slave_asserts.fail_cnt,
                 DUT.u_arb.u_arb_asserts.fail_cnt, tb_errors);
        if (chk_errors + tb_errors + DUT.u_slave.u_slave_asserts.fail_cnt
                + DUT.u_arb.u_arb_asserts.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/mem_pkg.sv
hdl/sram_array.sv
hdl/sram_slave.sv
hdl/bus_arbiter.sv
hdl/mem_subsystem.sv
bench/mem_checker.sv
bench/mem_subsystem_asserts.sv
bench/tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, pass only if the log holds the pass line
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsystem \
    -f tb.f -o sim > build.log 2>&1 \
    || { cat build.log; echo "compile failed"; exit 1; }
./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log && exit 0 || exit 1
